//--- include/mxint_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed sizes for a 4x8 by 4x8 MXINT linear layer built from 2x2 blocks
// Exponents are plain two's complement with no bias
// Tensor sizes must be multiples of the block edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MXINT_DEFS_SVH
`define MXINT_DEFS_SVH

// Mantissa and exponent widths
`define MAN_W 8
`define EXP_W 4
// Two 8x8 products summed
`define PROD_W 17
`define ACC_W 32
`define ACC_EXP_W 6

// Tensor shape, out = x * w^T + bias
`define IN_SIZE 8
`define OUT_SIZE 4
`define ROWS 4

// Block edge and block element count
`define PAR 2
`define BLK_N (`PAR * `PAR)

// Blocks along each dimension
`define IN_DEPTH (`IN_SIZE / `PAR)
`define OUT_DEPTH (`OUT_SIZE / `PAR)
`define ROW_DEPTH (`ROWS / `PAR)
`define CNT_W 3

`endif

//--- src/mxint_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared MXINT types, widths come from mxint_defs.svh
// Block mantissas are indexed row * PAR + col
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mxint_defs.svh"

package mxint_pkg;

  typedef logic signed [`MAN_W-1:0] man_t;
  typedef logic signed [`EXP_W-1:0] exp_t;
  typedef logic signed [`PROD_W-1:0] prod_t;
  typedef logic signed [`ACC_W-1:0] acc_t;
  typedef logic signed [`ACC_EXP_W-1:0] acc_exp_t;

  // Input and weight block, one shared exponent
  typedef struct packed {
    man_t [`BLK_N-1:0] man;
    exp_t              exp;
  } blk_t;

  // One bias row slice, one mantissa per output column
  typedef struct packed {
    man_t [`PAR-1:0] man;
    exp_t            exp;
  } bias_blk_t;

  typedef struct packed {
    prod_t [`BLK_N-1:0] man;
    acc_exp_t           exp;
  } fdp_blk_t;

  typedef struct packed {
    acc_t [`BLK_N-1:0] man;
    acc_exp_t          exp;
  } acc_blk_t;

  typedef struct packed {
    man_t [`BLK_N-1:0] man;
    acc_exp_t          exp;
  } out_blk_t;

  typedef enum logic [1:0] {ACC_IDLE, ACC_RUN, ACC_HOLD} acc_state_t;

endpackage

//--- src/mxint_circular.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fill-then-replay buffer for blocks of any packed type T
// Output is valid only once all BUFFER_SIZE entries are written
// Writes and reads never overlap, so REPEAT of 1 gives no pipelining
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_circular #(
  parameter int BUFFER_SIZE = `IN_DEPTH,
  parameter int REPEAT = `OUT_DEPTH,
  parameter type T = mxint_pkg::blk_t
) (
  input  logic clk,
  input  logic rst,
  input  T     in_blk,
  input  logic in_valid,
  output logic in_ready,
  output T     out_blk,
  output logic out_valid,
  input  logic out_ready
);

  localparam int FILL_W = $clog2(BUFFER_SIZE + 1);
  localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
  localparam int PASS_W = (REPEAT > 1) ? $clog2(REPEAT) : 1;

  T mem [BUFFER_SIZE];

  // Write pointer doubles as the fill count
  logic [FILL_W-1:0] wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PASS_W-1:0] pass;
  logic              wr_fire;
  logic              rd_fire;
  logic              last_slot;
  logic              last_pass;

  assign in_ready  = (wr_ptr != FILL_W'(BUFFER_SIZE));
  assign out_valid = !in_ready;
  assign out_blk   = mem[rd_ptr];

  assign wr_fire   = in_valid && in_ready;
  assign rd_fire   = out_valid && out_ready;
  assign last_slot = (rd_ptr == PTR_W'(BUFFER_SIZE - 1));
  assign last_pass = (pass == PASS_W'(REPEAT - 1));

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr[PTR_W-1:0]] <= in_blk;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      pass   <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= wr_ptr + FILL_W'(1);
      end
      if (rd_fire) begin
        if (last_slot) begin
          rd_ptr <= '0;
          if (last_pass) begin
            // Final read of final pass reopens the buffer
            pass   <= '0;
            wr_ptr <= '0;
          end else begin
            pass <= pass + PASS_W'(1);
          end
        end else begin
          rd_ptr <= rd_ptr + PTR_W'(1);
        end
      end
    end
  end

  // A write refused while full stays pending on the input until taken
  assert property (@(posedge clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable(in_blk))
    else $error("circular buffer write withdrawn before it was taken");

endmodule

//--- src/mxint_dot_product.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2x2 block product data * weight^T with a one-entry output register
// Result exponent is the plain sum of both exponents, no rounding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_dot_product (
  input  logic                 clk,
  input  logic                 rst,
  input  mxint_pkg::blk_t      data_blk,
  input  mxint_pkg::blk_t      weight_blk,
  input  logic                 in_valid,
  output logic                 in_ready,
  output mxint_pkg::fdp_blk_t  out_blk,
  output logic                 out_valid,
  input  logic                 out_ready
);

  mxint_pkg::fdp_blk_t prod_blk;
  logic                in_fire;

  // Accept when empty or when the held result leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_comb begin
    mxint_pkg::prod_t a;
    mxint_pkg::prod_t b;
    mxint_pkg::prod_t acc;
    for (int i = 0; i < `PAR; i++) begin
      for (int j = 0; j < `PAR; j++) begin
        acc = '0;
        // Row i of data against row j of weight
        for (int t = 0; t < `PAR; t++) begin
          a   = mxint_pkg::prod_t'($signed(data_blk.man[i*`PAR+t]));
          b   = mxint_pkg::prod_t'($signed(weight_blk.man[j*`PAR+t]));
          acc = acc + a * b;
        end
        prod_blk.man[i*`PAR+j] = acc;
      end
    end
    prod_blk.exp = mxint_pkg::acc_exp_t'($signed(data_blk.exp)) +
                   mxint_pkg::acc_exp_t'($signed(weight_blk.exp));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_blk <= prod_blk;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_blk))
    else $error("dot product result changed while stalled");

endmodule

//--- src/mxint_accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sums IN_DEPTH block terms, aligning each pair to the larger exponent
// Alignment shifts truncate toward minus infinity, overflow wraps
// accum_count reports which term is expected next
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_accumulator #(
  parameter int IN_DEPTH = `IN_DEPTH + 1
) (
  input  logic                clk,
  input  logic                rst,
  input  mxint_pkg::acc_blk_t term,
  input  logic                term_valid,
  output logic                term_ready,
  output mxint_pkg::acc_blk_t sum,
  output logic                sum_valid,
  input  logic                sum_ready,
  output logic [`CNT_W-1:0]   accum_count
);

  localparam int CNT_W = `CNT_W;
  localparam int EDW = `ACC_EXP_W + 1;

  mxint_pkg::acc_state_t state;
  mxint_pkg::acc_blk_t   merged;
  logic signed [EDW-1:0] exp_diff;
  logic [EDW-1:0]        shift_sum;
  logic [EDW-1:0]        shift_term;
  logic                  term_fire;
  logic                  last_term;

  // Result sits in the running register while in HOLD
  assign sum_valid  = (state == mxint_pkg::ACC_HOLD);
  assign term_ready = (state != mxint_pkg::ACC_HOLD) || sum_ready;
  assign term_fire  = term_valid && term_ready;
  assign last_term  = (accum_count == CNT_W'(IN_DEPTH - 1));

  always_comb begin
    exp_diff = EDW'($signed(term.exp)) - EDW'($signed(sum.exp));
    if ($signed(term.exp) > $signed(sum.exp)) begin
      shift_sum  = exp_diff;
      shift_term = '0;
      merged.exp = term.exp;
    end else begin
      shift_sum  = '0;
      shift_term = -exp_diff;
      merged.exp = sum.exp;
    end
    for (int i = 0; i < `BLK_N; i++) begin
      merged.man[i] = ($signed(sum.man[i]) >>> shift_sum) +
                      ($signed(term.man[i]) >>> shift_term);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= mxint_pkg::ACC_IDLE;
      accum_count <= '0;
    end else if (term_fire) begin
      accum_count <= last_term ? '0 : accum_count + CNT_W'(1);
      state       <= last_term ? mxint_pkg::ACC_HOLD : mxint_pkg::ACC_RUN;
    end else if (sum_valid && sum_ready) begin
      state <= mxint_pkg::ACC_IDLE;
    end
  end

  // First term of a group loads as is
  always_ff @(posedge clk) begin
    if (term_fire) begin
      sum <= (state == mxint_pkg::ACC_RUN) ? merged : term;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    accum_count <= CNT_W'(IN_DEPTH - 1) &&
    ((state == mxint_pkg::ACC_RUN) == (accum_count != '0)))
    else $error("accumulator count out of step with its state");

endmodule

//--- src/mxint_cast.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Normalises an accumulator block down to 8-bit mantissas
// Uses the smallest right shift that fits every mantissa
// Shifted-out bits are dropped, exponent saturates at the top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_cast (
  input  logic                clk,
  input  logic                rst,
  input  mxint_pkg::acc_blk_t in_blk,
  input  logic                in_valid,
  output logic                in_ready,
  output mxint_pkg::out_blk_t out_blk,
  output logic                out_valid,
  input  logic                out_ready
);

  localparam int MAX_SHIFT = `ACC_W - `MAN_W;
  localparam int SH_W = $clog2(MAX_SHIFT + 1);
  localparam int XW = `ACC_EXP_W + 2;
  localparam int MAN_MAX = (1 << (`MAN_W - 1)) - 1;
  localparam int MAN_MIN = -(MAN_MAX + 1);
  localparam int EXP_MAX = (1 << (`ACC_EXP_W - 1)) - 1;

  logic [SH_W-1:0]      shift;
  logic signed [XW-1:0] exp_wide;
  mxint_pkg::out_blk_t  cast_blk;
  logic                 in_fire;

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  // Scan down so the smallest fitting shift is kept
  always_comb begin
    logic fits;
    logic signed [`ACC_W-1:0] t;
    shift = SH_W'(MAX_SHIFT);
    for (int s = MAX_SHIFT; s >= 0; s--) begin
      fits = 1'b1;
      for (int i = 0; i < `BLK_N; i++) begin
        t = $signed(in_blk.man[i]) >>> s;
        if (t > MAN_MAX || t < MAN_MIN) begin
          fits = 1'b0;
        end
      end
      if (fits) begin
        shift = SH_W'(s);
      end
    end
  end

  always_comb begin
    logic signed [`ACC_W-1:0] wide;
    for (int i = 0; i < `BLK_N; i++) begin
      wide = $signed(in_blk.man[i]) >>> shift;
      cast_blk.man[i] = wide[`MAN_W-1:0];
    end
    // Shift only raises the exponent so only the top can overflow
    exp_wide = XW'($signed(in_blk.exp)) + XW'($signed({1'b0, shift}));
    if (exp_wide > XW'(EXP_MAX)) begin
      cast_blk.exp = `ACC_EXP_W'(EXP_MAX);
    end else begin
      cast_blk.exp = exp_wide[`ACC_EXP_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_blk <= cast_blk;
    end
  end

endmodule

//--- src/mxint_linear.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MXINT linear layer out = x * w^T + bias on 2x2 blocks
// Input blocks come per row-block, weights per column block then k
// All weights and bias must be loaded before the first result appears
// Output blocks leave in row-block then column-block order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_linear (
  input  logic                 clk,
  input  logic                 rst,
  input  mxint_pkg::blk_t      data_in,
  input  logic                 data_in_valid,
  output logic                 data_in_ready,
  input  mxint_pkg::blk_t      weight_in,
  input  logic                 weight_valid,
  output logic                 weight_ready,
  input  mxint_pkg::bias_blk_t bias_in,
  input  logic                 bias_valid,
  output logic                 bias_ready,
  output mxint_pkg::out_blk_t  data_out,
  output logic                 data_out_valid,
  input  logic                 data_out_ready
);

  localparam int CNT_W = `CNT_W;

  mxint_pkg::blk_t      buf_data;
  logic                 buf_data_valid;
  logic                 buf_data_ready;
  mxint_pkg::blk_t      buf_weight;
  logic                 buf_weight_valid;
  logic                 buf_weight_ready;
  mxint_pkg::bias_blk_t buf_bias;
  logic                 buf_bias_valid;
  logic                 buf_bias_ready;

  logic                 fdp_in_valid;
  logic                 fdp_in_ready;
  mxint_pkg::fdp_blk_t  fdp_blk;
  logic                 fdp_valid;
  logic                 fdp_ready;

  mxint_pkg::acc_blk_t  acc_term;
  logic                 acc_term_valid;
  logic                 acc_term_ready;
  mxint_pkg::acc_blk_t  acc_sum;
  logic                 acc_sum_valid;
  logic                 acc_sum_ready;
  logic [`CNT_W-1:0]    accum_count;
  logic                 add_bias;

  // Current row-block, replayed once per output column block
  mxint_circular #(
    .BUFFER_SIZE(`IN_DEPTH),
    .REPEAT     (`OUT_DEPTH),
    .T          (mxint_pkg::blk_t)
  ) data_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_blk   (data_in),
    .in_valid (data_in_valid),
    .in_ready (data_in_ready),
    .out_blk  (buf_data),
    .out_valid(buf_data_valid),
    .out_ready(buf_data_ready)
  );

  // Whole weight matrix, replayed once per row-block
  mxint_circular #(
    .BUFFER_SIZE(`IN_DEPTH * `OUT_DEPTH),
    .REPEAT     (`ROW_DEPTH),
    .T          (mxint_pkg::blk_t)
  ) weight_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_blk   (weight_in),
    .in_valid (weight_valid),
    .in_ready (weight_ready),
    .out_blk  (buf_weight),
    .out_valid(buf_weight_valid),
    .out_ready(buf_weight_ready)
  );

  mxint_circular #(
    .BUFFER_SIZE(`OUT_DEPTH),
    .REPEAT     (`ROW_DEPTH),
    .T          (mxint_pkg::bias_blk_t)
  ) bias_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_blk   (bias_in),
    .in_valid (bias_valid),
    .in_ready (bias_ready),
    .out_blk  (buf_bias),
    .out_valid(buf_bias_valid),
    .out_ready(buf_bias_ready)
  );

  // Join of data and weight streams
  assign fdp_in_valid     = buf_data_valid && buf_weight_valid;
  assign buf_data_ready   = fdp_in_ready && buf_weight_valid;
  assign buf_weight_ready = fdp_in_ready && buf_data_valid;

  mxint_dot_product dot_product (
    .clk       (clk),
    .rst       (rst),
    .data_blk  (buf_data),
    .weight_blk(buf_weight),
    .in_valid  (fdp_in_valid),
    .in_ready  (fdp_in_ready),
    .out_blk   (fdp_blk),
    .out_valid (fdp_valid),
    .out_ready (fdp_ready)
  );

  // Bias goes in as the last term of every output block
  assign add_bias       = (accum_count == CNT_W'(`IN_DEPTH));
  assign acc_term_valid = add_bias ? buf_bias_valid : fdp_valid;
  assign buf_bias_ready = add_bias && acc_term_ready;
  assign fdp_ready      = !add_bias && acc_term_ready;

  always_comb begin
    for (int i = 0; i < `PAR; i++) begin
      for (int j = 0; j < `PAR; j++) begin
        if (add_bias) begin
          // Same bias column for both rows of the block
          acc_term.man[i*`PAR+j] = mxint_pkg::acc_t'($signed(buf_bias.man[j]));
        end else begin
          acc_term.man[i*`PAR+j] = mxint_pkg::acc_t'($signed(fdp_blk.man[i*`PAR+j]));
        end
      end
    end
    acc_term.exp = add_bias ? mxint_pkg::acc_exp_t'($signed(buf_bias.exp)) : fdp_blk.exp;
  end

  mxint_accumulator #(
    .IN_DEPTH(`IN_DEPTH + 1)
  ) accumulator (
    .clk        (clk),
    .rst        (rst),
    .term       (acc_term),
    .term_valid (acc_term_valid),
    .term_ready (acc_term_ready),
    .sum        (acc_sum),
    .sum_valid  (acc_sum_valid),
    .sum_ready  (acc_sum_ready),
    .accum_count(accum_count)
  );

  mxint_cast cast (
    .clk      (clk),
    .rst      (rst),
    .in_blk   (acc_sum),
    .in_valid (acc_sum_valid),
    .in_ready (acc_sum_ready),
    .out_blk  (data_out),
    .out_valid(data_out_valid),
    .out_ready(data_out_ready)
  );

endmodule

//--- testbench/mxint_linear_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the MXINT linear layer, stimulus from a fixed-seed LFSR
// Expected blocks come from a matrix-level model of the block arithmetic
// Stops at the first mismatch or timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mxint_defs.svh"

module mxint_linear_tb;

  localparam int TIMEOUT = 2000;
  localparam int N_OUT = `ROW_DEPTH * `OUT_DEPTH;

  logic                 clk;
  logic                 rst;
  mxint_pkg::blk_t      data_in;
  logic                 data_in_valid;
  logic                 data_in_ready;
  mxint_pkg::blk_t      weight_in;
  logic                 weight_valid;
  logic                 weight_ready;
  mxint_pkg::bias_blk_t bias_in;
  logic                 bias_valid;
  logic                 bias_ready;
  mxint_pkg::out_blk_t  data_out;
  logic                 data_out_valid;
  logic                 data_out_ready;

  logic [31:0] lfsr;
  string       test_name;

  // Tensors of the current inference, block exponents kept per block
  int x_m [`ROWS][`IN_SIZE];
  int x_e [`ROW_DEPTH][`IN_DEPTH];
  int w_m [`OUT_SIZE][`IN_SIZE];
  int w_e [`OUT_DEPTH][`IN_DEPTH];
  int b_m [`OUT_SIZE];
  int b_e [`OUT_DEPTH];

  mxint_linear UUT (
    .clk           (clk),
    .rst           (rst),
    .data_in       (data_in),
    .data_in_valid (data_in_valid),
    .data_in_ready (data_in_ready),
    .weight_in     (weight_in),
    .weight_valid  (weight_valid),
    .weight_ready  (weight_ready),
    .bias_in       (bias_in),
    .bias_valid    (bias_valid),
    .bias_ready    (bias_ready),
    .data_out      (data_out),
    .data_out_valid(data_out_valid),
    .data_out_ready(data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Right-shifting Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'hD0000001;
    end
    return b;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  // all_min forces every mantissa to -128 and widens the exponent spread
  function automatic void fill_tensors(input bit all_min);
    for (int r = 0; r < `ROWS; r++) begin
      for (int i = 0; i < `IN_SIZE; i++) begin
        x_m[r][i] = all_min ? -128 : rand_bits(8) - 128;
        w_m[r][i] = all_min ? -128 : rand_bits(8) - 128;
      end
      b_m[r] = all_min ? -128 : rand_bits(8) - 128;
    end
    for (int a = 0; a < `ROW_DEPTH; a++) begin
      for (int k = 0; k < `IN_DEPTH; k++) begin
        x_e[a][k] = all_min ? rand_bits(4) - 8 : rand_bits(3) - 4;
        w_e[a][k] = all_min ? rand_bits(4) - 8 : rand_bits(3) - 4;
      end
      b_e[a] = all_min ? rand_bits(4) - 8 : rand_bits(3) - 4;
    end
  endfunction

  function automatic mxint_pkg::blk_t make_data(input int r, input int k);
    mxint_pkg::blk_t b;
    for (int i = 0; i < `PAR; i++) begin
      for (int j = 0; j < `PAR; j++) begin
        b.man[i*`PAR+j] = mxint_pkg::man_t'(x_m[`PAR*r+i][`PAR*k+j]);
      end
    end
    b.exp = mxint_pkg::exp_t'(x_e[r][k]);
    return b;
  endfunction

  function automatic mxint_pkg::blk_t make_weight(input int c, input int k);
    mxint_pkg::blk_t b;
    for (int i = 0; i < `PAR; i++) begin
      for (int j = 0; j < `PAR; j++) begin
        b.man[i*`PAR+j] = mxint_pkg::man_t'(w_m[`PAR*c+i][`PAR*k+j]);
      end
    end
    b.exp = mxint_pkg::exp_t'(w_e[c][k]);
    return b;
  endfunction

  function automatic mxint_pkg::bias_blk_t make_bias(input int c);
    mxint_pkg::bias_blk_t b;
    for (int j = 0; j < `PAR; j++) begin
      b.man[j] = mxint_pkg::man_t'(b_m[`PAR*c+j]);
    end
    b.exp = mxint_pkg::exp_t'(b_e[c]);
    return b;
  endfunction

  // Expected output block (r, c): four dot-product terms, then bias, then cast
  function automatic mxint_pkg::out_blk_t ref_block(input int r, input int c);
    mxint_pkg::out_blk_t res;
    int  acc_m [`BLK_N];
    int  t_m [`BLK_N];
    int  acc_e;
    int  t_e;
    int  s;
    int  e;
    bit  fits;
    acc_e = 0;
    for (int k = 0; k <= `IN_DEPTH; k++) begin
      for (int i = 0; i < `PAR; i++) begin
        for (int j = 0; j < `PAR; j++) begin
          if (k == `IN_DEPTH) begin
            t_m[i*`PAR+j] = b_m[`PAR*c+j];
          end else begin
            t_m[i*`PAR+j] = 0;
            for (int t = 0; t < `PAR; t++) begin
              t_m[i*`PAR+j] += x_m[`PAR*r+i][`PAR*k+t] * w_m[`PAR*c+j][`PAR*k+t];
            end
          end
        end
      end
      t_e = (k == `IN_DEPTH) ? b_e[c] : x_e[r][k] + w_e[c][k];
      // Smaller exponent side loses its low bits
      for (int n = 0; n < `BLK_N; n++) begin
        if (k == 0) begin
          acc_m[n] = t_m[n];
        end else if (t_e > acc_e) begin
          acc_m[n] = (acc_m[n] >>> (t_e - acc_e)) + t_m[n];
        end else begin
          acc_m[n] = acc_m[n] + (t_m[n] >>> (acc_e - t_e));
        end
      end
      if (k == 0 || t_e > acc_e) begin
        acc_e = t_e;
      end
    end
    s = 0;
    fits = 1'b0;
    while (!fits) begin
      fits = 1'b1;
      for (int n = 0; n < `BLK_N; n++) begin
        if ((acc_m[n] >>> s) > 127 || (acc_m[n] >>> s) < -128) begin
          fits = 1'b0;
        end
      end
      if (!fits) begin
        s++;
      end
    end
    for (int n = 0; n < `BLK_N; n++) begin
      res.man[n] = mxint_pkg::man_t'(acc_m[n] >>> s);
    end
    e = (acc_e + s > 31) ? 31 : acc_e + s;
    res.exp = mxint_pkg::acc_exp_t'(e);
    return res;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_out_blk(input mxint_pkg::out_blk_t expected,
                               input mxint_pkg::out_blk_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error %s: expected %h, actual %h", test_name, expected, actual));
    end
  endtask

  task automatic check_count(input int expected, input int actual);
    if (actual != expected) begin
      fail_run($sformatf("** Error %s block count: expected %0d, actual %0d",
                         test_name, expected, actual));
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error %s: expected %b, actual %b", what, expected, actual));
    end
  endtask

  function automatic logic stream_ready(input int which);
    case (which)
      0:       return data_in_ready;
      1:       return weight_ready;
      default: return bias_ready;
    endcase
  endfunction

  function automatic string stream_name(input int which);
    case (which)
      0:       return "data_in";
      1:       return "weight_in";
      default: return "bias_in";
    endcase
  endfunction

  // Stream 0 is data, 1 is weights, 2 is bias; driven on falling edges
  task automatic feed_stream(input int which, input int delay, input int max_gap);
    int total;
    int waited;
    total = (which == 0) ? `ROW_DEPTH * `IN_DEPTH :
            (which == 1) ? `OUT_DEPTH * `IN_DEPTH : `OUT_DEPTH;
    repeat (delay) @(negedge clk);
    for (int n = 0; n < total; n++) begin
      if (max_gap > 0) begin
        repeat (rand_bits(3) % (max_gap + 1)) @(negedge clk);
      end
      case (which)
        0: begin
          data_in = make_data(n / `IN_DEPTH, n % `IN_DEPTH);
          data_in_valid = 1'b1;
        end
        1: begin
          weight_in = make_weight(n / `IN_DEPTH, n % `IN_DEPTH);
          weight_valid = 1'b1;
        end
        default: begin
          bias_in = make_bias(n);
          bias_valid = 1'b1;
        end
      endcase
      waited = 0;
      while (!stream_ready(which)) begin
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT) begin
          fail_run($sformatf("Timeout: %s stream was never ready in %s",
                             stream_name(which), test_name));
        end
      end
      // Transfer takes place on the rising edge in between
      @(negedge clk);
      case (which)
        0:       data_in_valid = 1'b0;
        1:       weight_valid = 1'b0;
        default: bias_valid = 1'b0;
      endcase
    end
  endtask

  task automatic collect_outputs(input bit random_ready);
    int got;
    int extra;
    int waited;
    got = 0;
    waited = 0;
    while (got < N_OUT) begin
      @(negedge clk);
      data_out_ready = random_ready ? next_bit() : 1'b1;
      if (data_out_valid && data_out_ready) begin
        check_out_blk(ref_block(got / `OUT_DEPTH, got % `OUT_DEPTH), data_out);
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > TIMEOUT) begin
          fail_run($sformatf("Timeout: output block %0d never arrived in %s", got, test_name));
        end
      end
    end
    // Any further block here would be a duplicate
    extra = 0;
    repeat (20) begin
      @(negedge clk);
      data_out_ready = 1'b1;
      if (data_out_valid) begin
        extra++;
      end
    end
    check_count(N_OUT, got + extra);
  endtask

  task automatic run_inference(input string name, input bit random_ready, input int data_gap,
                               input int wb_delay, input int wb_gap);
    test_name = name;
    fork
      feed_stream(0, 0, data_gap);
      feed_stream(1, wb_delay, wb_gap);
      feed_stream(2, wb_delay, wb_gap);
      collect_outputs(random_ready);
    join
  endtask

  initial begin
    lfsr = 32'h753f0375;
    rst = 1'b1;
    data_in = '0;
    data_in_valid = 1'b0;
    weight_in = '0;
    weight_valid = 1'b0;
    bias_in = '0;
    bias_valid = 1'b0;
    data_out_ready = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("data_out_valid after reset", 1'b0, data_out_valid);
    check_bit("data_in_ready after reset", 1'b1, data_in_ready);
    check_bit("weight_ready after reset", 1'b1, weight_ready);
    check_bit("bias_ready after reset", 1'b1, bias_ready);

    fill_tensors(1'b0);
    run_inference("random", 1'b0, 0, 0, 0);
    run_inference("random_backpressure", 1'b1, 0, 0, 0);
    fill_tensors(1'b0);
    run_inference("late_weights_with_gaps", 1'b0, 3, 12, 4);
    fill_tensors(1'b1);
    run_inference("min_mantissa", 1'b1, 0, 0, 0);
    fill_tensors(1'b0);
    run_inference("consecutive_first", 1'b0, 0, 0, 0);
    fill_tensors(1'b0);
    run_inference("consecutive_second", 1'b0, 0, 0, 0);

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
src/mxint_pkg.sv
src/mxint_circular.sv
src/mxint_dot_product.sv
src/mxint_accumulator.sv
src/mxint_cast.sv
src/mxint_linear.sv
testbench/mxint_linear_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the MXINT linear layer testbench with Verilator and runs it.
# The exit status is nonzero when the build or any check fails.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module mxint_linear_tb -f compile.f -o mxint_linear_sim \
  && ./obj_dir/mxint_linear_sim \
  || { echo "Simulation did not complete cleanly"; exit 1; }
